/* build.f */
+incdir+include
logic/ppu_pkg.sv
logic/ppu_ifs.sv
logic/n64_vdemux.sv
logic/n64_vinfo.sv
logic/ppu_ctrl.sv
logic/color_proc.sv
logic/ppu_top.sv
verification/ppu_chk.sv
verification/ppu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module ppu_tb -o ppu_sim \
  && ./obj_dir/ppu_sim | tee sim.log \
  || echo "build or simulation did not complete"
grep -q "^TESTS PASSED$" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verification/ppu_tb.sv */
/*
  PPU input side testbench
*/

`default_nettype none

`include "ppu_consts.svh"

module ppu_tb import ppu_pkg::*; ();

  localparam int NUM_FIELDS    = 16;
  localparam int LINE_PIX      = 8;
  localparam int WORDS_PER_PIX = 4;
  localparam int CLK_PERIOD    = 4;

  // PAL run, NTSC run, alternating 480i run, back to PAL
  localparam int FIELD_LINES [NUM_FIELDS] = '{
    313, 313, 313, 313, 263, 263, 263, 263,
    262, 263, 262, 263, 263, 263, 313, 313
  };

  typedef struct packed {
    logic             vs_n;
    logic             hs_n;
    logic             cs_n;
    logic [`CO_W-1:0] r;
    logic [`CO_W-1:0] g;
    logic [`CO_W-1:0] b;
  } exp_pix_t;

  logic                N64_CLK_i;
  logic                rst_n_i;
  logic                n_vdsync;
  vd_word_u            vd;
  logic [`GAMMA_W-1:0] cfg_gamma;
  logic                cfg_16bit;
  logic                cfg_force50;
  logic                cfg_force60;

  logic                pix_valid_o;
  logic                vsync_n_o;
  logic                hsync_n_o;
  logic                csync_n_o;
  logic [`CO_W-1:0]    r_o;
  logic [`CO_W-1:0]    g_o;
  logic [`CO_W-1:0]    b_o;
  logic                vdata_detected_o;
  logic                palmode_o;
  logic                n64_480i_o;
  logic                mode_50hz_o;

  // config as the DUT should have latched it
  logic [`GAMMA_W-1:0] lat_gamma;
  logic                lat_16bit;
  logic                lat_f50;
  logic                lat_f60;

  exp_pix_t exp_q [$];
  integer   seed;
  int       checked;

  ppu_top ppu_top_inst (
    .N64_CLK_i       (N64_CLK_i),
    .rst_n_i         (rst_n_i),
    .n_vdsync_i      (n_vdsync),
    .vd_i            (vd),
    .cfg_gamma_i     (cfg_gamma),
    .cfg_16bit_i     (cfg_16bit),
    .cfg_force50_i   (cfg_force50),
    .cfg_force60_i   (cfg_force60),
    .pix_valid_o     (pix_valid_o),
    .vsync_n_o       (vsync_n_o),
    .hsync_n_o       (hsync_n_o),
    .csync_n_o       (csync_n_o),
    .r_o             (r_o),
    .g_o             (g_o),
    .b_o             (b_o),
    .vdata_detected_o(vdata_detected_o),
    .palmode_o       (palmode_o),
    .n64_480i_o      (n64_480i_o),
    .mode_50hz_o     (mode_50hz_o)
  );

  always #(CLK_PERIOD / 2) N64_CLK_i = ~N64_CLK_i;

  // ==============================
  // reference model
  // ==============================

  function automatic logic [`CO_W-1:0] model_color(input logic [`VD_W-1:0] c,
                                                   input logic m16,
                                                   input logic [`GAMMA_W-1:0] sel);
    int v;
    int x;
    v = m16 ? (int'(c) & 32'h7c) : int'(c);
    // seven bits on top, msb copied into bit 0
    x = v * 2 + v / 64;
    case (sel)
      `GAMMA_DARK:   x = (x * x) / 256;
      `GAMMA_BRIGHT: x = 255 - ((255 - x) * (255 - x)) / 256;
      default:       x = x;
    endcase
    return x[`CO_W-1:0];
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_pixel(input logic [`CO_W-1:0] exp_r, input logic [`CO_W-1:0] exp_g,
                               input logic [`CO_W-1:0] exp_b, input logic exp_vs_n,
                               input logic exp_hs_n, input logic exp_cs_n);
    if (r_o !== exp_r || g_o !== exp_g || b_o !== exp_b || vsync_n_o !== exp_vs_n ||
        hsync_n_o !== exp_hs_n || csync_n_o !== exp_cs_n) begin
      report_error($sformatf("pixel %0d rgb %h %h %h sync %b%b%b, expected %h %h %h sync %b%b%b",
                             checked, r_o, g_o, b_o, vsync_n_o, hsync_n_o, csync_n_o,
                             exp_r, exp_g, exp_b, exp_vs_n, exp_hs_n, exp_cs_n));
    end
  endtask

  task automatic compare_state(input logic exp_det, input logic exp_pal,
                               input logic exp_480i, input logic exp_50hz);
    if ({vdata_detected_o, palmode_o, n64_480i_o, mode_50hz_o} !==
        {exp_det, exp_pal, exp_480i, exp_50hz}) begin
      report_error($sformatf("state det/pal/480i/50hz %b%b%b%b, expected %b%b%b%b",
                             vdata_detected_o, palmode_o, n64_480i_o, mode_50hz_o,
                             exp_det, exp_pal, exp_480i, exp_50hz));
    end
  endtask

  // expected flags after k field starts
  task automatic check_field_state(input int k);
    logic det;
    logic pal;
    logic i480;
    logic m50;
    det  = 1'b0;
    pal  = 1'b0;
    i480 = 1'b0;
    if (k >= 2) begin
      det = 1'b1;
      pal = FIELD_LINES[k-2] > `PAL_LINE_MIN;
    end
    if (k >= 3) begin
      i480 = FIELD_LINES[k-2] != FIELD_LINES[k-3];
    end
    if (!det || lat_f60) begin
      m50 = 1'b0;
    end else if (lat_f50) begin
      m50 = 1'b1;
    end else begin
      m50 = pal;
    end
    compare_state(det, pal, i480, m50);
  endtask

  // ==============================
  // stimulus
  // ==============================

  task automatic change_config(input int f);
    int rnd;
    rnd = $random(seed);
    cfg_gamma   = rnd[1:0];
    cfg_16bit   = rnd[2];
    // cycles through auto, force50, force60, both
    cfg_force50 = f[0];
    cfg_force60 = f[1];
  endtask

  task automatic send_pixel(input logic vs_n, input logic hs_n, input logic field_first);
    int               rnd;
    vd_word_u         sw;
    logic [`VD_W-1:0] r;
    logic [`VD_W-1:0] g;
    logic [`VD_W-1:0] b;
    exp_pix_t         e;
    rnd = $random(seed);
    r   = rnd[6:0];
    g   = rnd[13:7];
    b   = rnd[20:14];
    sw  = '0;
    sw.sync.vsync_n = vs_n;
    sw.sync.clamp_n = 1'b1;
    sw.sync.hsync_n = hs_n;
    sw.sync.csync_n = vs_n & hs_n;
    e.vs_n = vs_n;
    e.hs_n = hs_n;
    e.cs_n = vs_n & hs_n;
    // the field start pixel still uses the old config
    e.r = model_color(r, lat_16bit, lat_gamma);
    e.g = model_color(g, lat_16bit, lat_gamma);
    e.b = model_color(b, lat_16bit, lat_gamma);
    exp_q.push_back(e);
    if (field_first) begin
      lat_gamma = cfg_gamma;
      lat_16bit = cfg_16bit;
      lat_f50   = cfg_force50;
      lat_f60   = cfg_force60;
    end
    @(negedge N64_CLK_i);
    n_vdsync = 1'b0;
    vd       = sw;
    @(negedge N64_CLK_i);
    n_vdsync = 1'b1;
    vd.color = r;
    @(negedge N64_CLK_i);
    vd.color = g;
    @(negedge N64_CLK_i);
    vd.color = b;
  endtask

  initial begin
    seed        = 45322;
    N64_CLK_i   = 1'b0;
    rst_n_i     = 1'b0;
    n_vdsync    = 1'b1;
    vd          = '0;
    cfg_gamma   = `GAMMA_LIN;
    cfg_16bit   = 1'b0;
    cfg_force50 = 1'b0;
    cfg_force60 = 1'b0;
    lat_gamma   = `GAMMA_LIN;
    lat_16bit   = 1'b0;
    lat_f50     = 1'b0;
    lat_f60     = 1'b0;
    checked     = 0;
    repeat (2) @(negedge N64_CLK_i);
    rst_n_i = 1'b1;

    for (int f = 0; f < NUM_FIELDS; f++) begin
      check_field_state(f);
      for (int ln = 0; ln < FIELD_LINES[f]; ln++) begin
        if (ln == FIELD_LINES[f] / 2) begin
          change_config(f);
        end
        for (int p = 0; p < LINE_PIX; p++) begin
          send_pixel(ln != 0, p != 0, ln == 0 && p == 0);
        end
      end
    end
    check_field_state(NUM_FIELDS);

    // drain the pipeline, then give stray pixels a chance to show
    while (exp_q.size() != 0) begin
      @(negedge N64_CLK_i);
    end
    repeat (8) @(negedge N64_CLK_i);
    $display("TESTS PASSED");
    $finish;
  end

  // outputs only move on the rising edge
  always @(negedge N64_CLK_i) begin
    exp_pix_t e;
    if (rst_n_i && pix_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("output pixel at time %0t with no pixel pending", $time);
        $display("TESTS FAILED");
        $fatal(1, "stray output pixel");
      end else begin
        e = exp_q.pop_front();
        checked++;
        compare_pixel(e.r, e.g, e.b, e.vs_n, e.hs_n, e.cs_n);
      end
    end
  end

  // ==============================
  // watchdog
  // ==============================

  initial begin
    longint wd_cycles;
    wd_cycles = 0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      wd_cycles += FIELD_LINES[i] * LINE_PIX * WORDS_PER_PIX;
    end
    // reset, pipeline drain and slack
    wd_cycles += 256;
    #(wd_cycles * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before the run finished", wd_cycles);
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* verification/ppu_chk.sv */
/*
  PPU top level assertions
*/

`default_nettype none

module ppu_chk (
  input wire logic N64_CLK_i,
  input wire logic rst_n_i,
  input wire logic pix_valid_i,
  input wire logic detected_i,
  input wire logic palmode_i,
  input wire logic n64_480i_i,
  input wire logic mode_50hz_i,
  input wire logic field_start_i,
  input wire logic force60_i
);

  logic load_pend;
  logic force60_lat;

  // force60 as of the last config load, first cycle out of reset or field start
  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      load_pend   <= 1'b1;
      force60_lat <= 1'b0;
    end else begin
      load_pend <= 1'b0;
      if (load_pend || field_start_i) begin
        force60_lat <= force60_i;
      end
    end
  end

  // pixels are at least four cycles apart
  a_valid_single: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    !(pix_valid_i && $past(pix_valid_i)))
    else $error("pix_valid_o high in two consecutive cycles");

  a_modes_need_video: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    !detected_i |-> (!palmode_i && !n64_480i_i))
    else $error("palmode_o or n64_480i_o set without detected video");

  // latched force60 always wins
  a_force60: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    force60_lat |-> !mode_50hz_i)
    else $error("mode_50hz_o set while force60 is latched");

endmodule

bind ppu_top ppu_chk chk_inst (
  .N64_CLK_i    (N64_CLK_i),
  .rst_n_i      (rst_n_i),
  .pix_valid_i  (pix_valid_o),
  .detected_i   (vdata_detected_o),
  .palmode_i    (palmode_o),
  .n64_480i_i   (n64_480i_o),
  .mode_50hz_i  (mode_50hz_o),
  .field_start_i(vinfo_if_inst.field_start),
  .force60_i    (cfg_force60_i)
);

`default_nettype wire

/* logic/ppu_top.sv */
/*
  N64 post-processing top level
*/

`default_nettype none

`include "ppu_consts.svh"

module ppu_top import ppu_pkg::*; (
  input  wire logic                N64_CLK_i,
  input  wire logic                rst_n_i,
  input  wire logic                n_vdsync_i,
  input  wire logic [`VD_W-1:0]    vd_i,
  input  wire logic [`GAMMA_W-1:0] cfg_gamma_i,
  input  wire logic                cfg_16bit_i,
  input  wire logic                cfg_force50_i,
  input  wire logic                cfg_force60_i,
  output wire logic                pix_valid_o,
  output wire logic                vsync_n_o,
  output wire logic                hsync_n_o,
  output wire logic                csync_n_o,
  output wire logic [`CO_W-1:0]    r_o,
  output wire logic [`CO_W-1:0]    g_o,
  output wire logic [`CO_W-1:0]    b_o,
  output wire logic                vdata_detected_o,
  output wire logic                palmode_o,
  output wire logic                n64_480i_o,
  output wire logic                mode_50hz_o
);

  vd_word_u            vd_w;
  logic [`GAMMA_W-1:0] gamma_sel_w;
  logic                mode16_w;

  n64_pix_if pix_if ();
  vinfo_if   vinfo_if_inst ();

  assign vd_w = vd_i;

  // ==============================
  // input side
  // ==============================

  n64_vdemux vdemux_inst (
    .N64_CLK_i (N64_CLK_i),
    .rst_n_i   (rst_n_i),
    .n_vdsync_i(n_vdsync_i),
    .vd_i      (vd_w),
    .pix       (pix_if.src)
  );

  n64_vinfo vinfo_inst (
    .N64_CLK_i(N64_CLK_i),
    .rst_n_i  (rst_n_i),
    .pix      (pix_if.dst),
    .vinfo    (vinfo_if_inst.src)
  );

  ppu_ctrl ctrl_inst (
    .N64_CLK_i       (N64_CLK_i),
    .rst_n_i         (rst_n_i),
    .cfg_gamma_i     (cfg_gamma_i),
    .cfg_16bit_i     (cfg_16bit_i),
    .cfg_force50_i   (cfg_force50_i),
    .cfg_force60_i   (cfg_force60_i),
    .vinfo           (vinfo_if_inst.dst),
    .gamma_sel_o     (gamma_sel_w),
    .mode16_o        (mode16_w),
    .mode_50hz_o     (mode_50hz_o),
    .vdata_detected_o(vdata_detected_o),
    .palmode_o       (palmode_o),
    .n64_480i_o      (n64_480i_o)
  );

  // colour pipeline
  color_proc color_inst (
    .N64_CLK_i  (N64_CLK_i),
    .rst_n_i    (rst_n_i),
    .pix        (pix_if.dst),
    .gamma_sel_i(gamma_sel_w),
    .mode16_i   (mode16_w),
    .pix_valid_o(pix_valid_o),
    .vsync_n_o  (vsync_n_o),
    .hsync_n_o  (hsync_n_o),
    .csync_n_o  (csync_n_o),
    .r_o        (r_o),
    .g_o        (g_o),
    .b_o        (b_o)
  );

endmodule

`default_nettype wire

/* logic/color_proc.sv */
/*
  Colour depth, expansion and gamma
*/

`default_nettype none

`include "ppu_consts.svh"

module color_proc import ppu_pkg::*; (
  input  wire logic                N64_CLK_i,
  input  wire logic                rst_n_i,
  n64_pix_if.dst                   pix,
  input  wire logic [`GAMMA_W-1:0] gamma_sel_i,
  input  wire logic                mode16_i,
  output logic                     pix_valid_o,
  output logic                     vsync_n_o,
  output logic                     hsync_n_o,
  output logic                     csync_n_o,
  output logic [`CO_W-1:0]         r_o,
  output logic [`CO_W-1:0]         g_o,
  output logic [`CO_W-1:0]         b_o
);

  function automatic logic [`CO_W-1:0] expand(input logic [`VD_W-1:0] c, input logic m16);
    logic [`VD_W-1:0] cm;
    // 16-bit mode drops the two lsbs
    cm = m16 ? {c[`VD_W-1:2], 2'b00} : c;
    return {cm, cm[`VD_W-1]};
  endfunction

  function automatic logic [`CO_W-1:0] gamma(input logic [`GAMMA_W-1:0] sel,
                                             input logic [`CO_W-1:0] x);
    logic [2*`CO_W-1:0] sq;
    logic [`CO_W-1:0]   inv;
    sq  = '0;
    inv = ~x;
    case (sel)
      `GAMMA_DARK: begin
        sq = x * x;
        return sq[2*`CO_W-1:`CO_W];
      end
      `GAMMA_BRIGHT: begin
        // mirrored square of 255 - x
        sq = inv * inv;
        return ~sq[2*`CO_W-1:`CO_W];
      end
      default: return x;
    endcase
  endfunction

  // ==============================
  // stage one
  // ==============================

  logic                s1_valid;
  vd_word_u            s1_sync;
  logic [`CO_W-1:0]    s1_r;
  logic [`CO_W-1:0]    s1_g;
  logic [`CO_W-1:0]    s1_b;
  logic [`GAMMA_W-1:0] s1_gamma;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= pix.valid;
    end
  end

  // curve select rides with the pixel
  always_ff @(posedge N64_CLK_i) begin
    if (pix.valid) begin
      s1_sync  <= pix.sync;
      s1_r     <= expand(pix.r, mode16_i);
      s1_g     <= expand(pix.g, mode16_i);
      s1_b     <= expand(pix.b, mode16_i);
      s1_gamma <= gamma_sel_i;
    end
  end

  // ==============================
  // stage two
  // ==============================

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      pix_valid_o <= 1'b0;
      vsync_n_o   <= 1'b1;
      hsync_n_o   <= 1'b1;
      csync_n_o   <= 1'b1;
      r_o         <= '0;
      g_o         <= '0;
      b_o         <= '0;
    end else begin
      pix_valid_o <= s1_valid;
      if (s1_valid) begin
        vsync_n_o <= s1_sync.sync.vsync_n;
        hsync_n_o <= s1_sync.sync.hsync_n;
        csync_n_o <= s1_sync.sync.csync_n;
        r_o       <= gamma(s1_gamma, s1_r);
        g_o       <= gamma(s1_gamma, s1_g);
        b_o       <= gamma(s1_gamma, s1_b);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/ppu_ctrl.sv */
/*
  Config latch and refresh rate control
*/

`default_nettype none

`include "ppu_consts.svh"

module ppu_ctrl (
  input  wire logic               N64_CLK_i,
  input  wire logic               rst_n_i,
  input  wire logic [`GAMMA_W-1:0] cfg_gamma_i,
  input  wire logic               cfg_16bit_i,
  input  wire logic               cfg_force50_i,
  input  wire logic               cfg_force60_i,
  vinfo_if.dst                    vinfo,
  output logic [`GAMMA_W-1:0]     gamma_sel_o,
  output logic                    mode16_o,
  output logic                    mode_50hz_o,
  output logic                    vdata_detected_o,
  output logic                    palmode_o,
  output logic                    n64_480i_o
);

  logic load_pend;
  logic cfg_load;
  logic cfg_force50_q;
  logic cfg_force60_q;

  // first cycle out of reset, then once per field
  assign cfg_load = load_pend | vinfo.field_start;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      load_pend        <= 1'b1;
      gamma_sel_o      <= `GAMMA_LIN;
      mode16_o         <= 1'b0;
      cfg_force50_q    <= 1'b0;
      cfg_force60_q    <= 1'b0;
      vdata_detected_o <= 1'b0;
      palmode_o        <= 1'b0;
      n64_480i_o       <= 1'b0;
    end else begin
      load_pend <= 1'b0;
      if (cfg_load) begin
        gamma_sel_o   <= cfg_gamma_i;
        mode16_o      <= cfg_16bit_i;
        cfg_force50_q <= cfg_force50_i;
        cfg_force60_q <= cfg_force60_i;
      end
      vdata_detected_o <= vinfo.detected;
      palmode_o        <= vinfo.palmode;
      n64_480i_o       <= vinfo.n64_480i;
    end
  end

  // ==============================
  // refresh rate
  // ==============================

  // force60 wins over force50, auto follows palmode
  assign mode_50hz_o = vdata_detected_o & ~cfg_force60_q & (cfg_force50_q | palmode_o);

endmodule

`default_nettype wire

/* logic/n64_vinfo.sv */
/*
  Field line counter and mode detection
*/

`default_nettype none

`include "ppu_consts.svh"

module n64_vinfo import ppu_pkg::*; (
  input  wire logic N64_CLK_i,
  input  wire logic rst_n_i,
  n64_pix_if.dst    pix,
  vinfo_if.src      vinfo
);

  vd_word_u prev_sync;
  logic     vs_fall;
  logic     hs_fall;

  logic [`LCNT_W-1:0] line_cnt;
  logic [`LCNT_W-1:0] last_cnt;

  // 0 nothing seen, 1 first field open, 2 one field done, 3 two or more
  logic [1:0] field_cnt;

  logic field_start_q;
  logic palmode_q;
  logic n64_480i_q;
  logic detected_q;

  // edges against the previous sync word
  assign vs_fall = pix.valid & prev_sync.sync.vsync_n & ~pix.sync.sync.vsync_n;
  assign hs_fall = pix.valid & prev_sync.sync.hsync_n & ~pix.sync.sync.hsync_n;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      prev_sync     <= '1;
      line_cnt      <= '0;
      field_cnt     <= 2'd0;
      field_start_q <= 1'b0;
      palmode_q     <= 1'b0;
      n64_480i_q    <= 1'b0;
      detected_q    <= 1'b0;
    end else begin
      field_start_q <= vs_fall;
      if (pix.valid) begin
        prev_sync <= pix.sync;
      end
      if (vs_fall) begin
        // close the field, the new line already counts if hsync fell too
        line_cnt <= `LCNT_W'(hs_fall);
        if (field_cnt != 2'd3) begin
          field_cnt <= field_cnt + 2'd1;
        end
        if (field_cnt != 2'd0) begin
          detected_q <= 1'b1;
          palmode_q  <= line_cnt > `LCNT_W'(`PAL_LINE_MIN);
        end
        if (field_cnt >= 2'd2) begin
          n64_480i_q <= line_cnt != last_cnt;
        end
      end else if (hs_fall) begin
        line_cnt <= line_cnt + `LCNT_W'(1);
      end
    end
  end

  // count of the previous field
  always_ff @(posedge N64_CLK_i) begin
    if (vs_fall) begin
      last_cnt <= line_cnt;
    end
  end

  assign vinfo.field_start = field_start_q;
  assign vinfo.palmode     = palmode_q;
  assign vinfo.n64_480i    = n64_480i_q;
  assign vinfo.detected    = detected_q;

endmodule

`default_nettype wire

/* logic/n64_vdemux.sv */
/*
  N64 video bus demux
*/

`default_nettype none

`include "ppu_consts.svh"

module n64_vdemux import ppu_pkg::*; (
  input  wire logic N64_CLK_i,
  input  wire logic rst_n_i,
  input  wire logic n_vdsync_i,
  input  vd_word_u  vd_i,
  n64_pix_if.src    pix
);

  // word phase, 1..3 after the sync word, 0 when idle
  logic [1:0] phase;
  logic       blue_seen;
  logic       valid_q;

  // words collected so far
  vd_word_u         sync_c;
  logic [`VD_W-1:0] r_c;
  logic [`VD_W-1:0] g_c;

  // complete pixel, held until the next blue word
  vd_word_u         sync_q;
  logic [`VD_W-1:0] r_q;
  logic [`VD_W-1:0] g_q;
  logic [`VD_W-1:0] b_q;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      phase     <= 2'd0;
      blue_seen <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      valid_q   <= blue_seen;
      blue_seen <= 1'b0;
      if (!n_vdsync_i) begin
        phase <= 2'd1;
      end else if (phase != 2'd0) begin
        // wraps back to idle after blue
        phase <= phase + 2'd1;
      end
      if (n_vdsync_i && phase == 2'd3) begin
        blue_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (!n_vdsync_i) begin
      sync_c <= vd_i;
    end else begin
      case (phase)
        2'd1: r_c <= vd_i.color;
        2'd2: g_c <= vd_i.color;
        2'd3: begin
          sync_q <= sync_c;
          r_q    <= r_c;
          g_q    <= g_c;
          b_q    <= vd_i.color;
        end
        default: ;
      endcase
    end
  end

  assign pix.valid = valid_q;
  assign pix.sync  = sync_q;
  assign pix.r     = r_q;
  assign pix.g     = g_q;
  assign pix.b     = b_q;

endmodule

`default_nettype wire

/* logic/ppu_ifs.sv */
/*
  Pixel stream and video info interfaces
*/

`default_nettype none

`include "ppu_consts.svh"

// one demuxed pixel, valid is a single-cycle strobe
interface n64_pix_if;
  logic              valid;
  ppu_pkg::vd_word_u sync;
  logic [`VD_W-1:0]  r;
  logic [`VD_W-1:0]  g;
  logic [`VD_W-1:0]  b;

  modport src (
    output valid,
    output sync,
    output r,
    output g,
    output b
  );

  modport dst (
    input valid,
    input sync,
    input r,
    input g,
    input b
  );
endinterface

// field timing and detected video mode
interface vinfo_if;
  logic field_start;
  logic palmode;
  logic n64_480i;
  logic detected;

  modport src (
    output field_start,
    output palmode,
    output n64_480i,
    output detected
  );

  modport dst (
    input field_start,
    input palmode,
    input n64_480i,
    input detected
  );
endinterface

`default_nettype wire

/* logic/ppu_pkg.sv */
/*
  N64 post-processing types
*/

`default_nettype none

`include "ppu_consts.svh"

package ppu_pkg;

  // one bus word, either the sync nibble or a colour
  typedef union packed {
    struct packed {
      logic [2:0] unused;
      logic       vsync_n;
      logic       clamp_n;
      logic       hsync_n;
      logic       csync_n;
    } sync;
    logic [`VD_W-1:0] color;
  } vd_word_u;

endpackage

`default_nettype wire

/* include/ppu_consts.svh */
/*
  N64 post-processing constants
*/

`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// ==============================
// bus and colour widths
// ==============================

// N64 video bus word
`define VD_W 7

// colour after expansion
`define CO_W 8

// ==============================
// video info
// ==============================

`define LCNT_W 10

// more hsync falls per field than this means PAL
`define PAL_LINE_MIN 290

// ==============================
// gamma curve codes
// ==============================

`define GAMMA_W 2
`define GAMMA_LIN 2'd0
`define GAMMA_DARK 2'd1
`define GAMMA_BRIGHT 2'd2

`endif
